// File: src/mem_pkg.sv
package mem_pkg;

  // ---------------------------------------------------------------------
  // Memory bus geometry.
  // ---------------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // 1 KiB of word storage.
  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);

  // Cycles between acceptance and the ready pulse.
  localparam int unsigned WAIT_CYCLES = 2;
  localparam int unsigned WAIT_CNT_W  = $clog2(WAIT_CYCLES + 1);

  // Which requester currently holds the shared bus.
  typedef enum logic {
    OWNER_INSTR = 1'b0,
    OWNER_DATA  = 1'b1
  } owner_t;

endpackage

// File: src/lsu_pkg.sv
package lsu_pkg;

  // ---------------------------------------------------------------------
  // Load/store opcodes.
  // ---------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LBU = 3'd1,
    OP_LH  = 3'd2,
    OP_LHU = 3'd3,
    OP_LW  = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
  } lsu_op_t;

  // Requester state, shared by fetch and LSU.
  typedef enum logic {
    IDLE       = 1'b0,
    WAIT_READY = 1'b1
  } req_state_t;

  function automatic logic is_store(lsu_op_t op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_en,
  input  logic                       redirect,
  input  logic [mem_pkg::ADDR_W-1:0] redirect_pc,
  input  logic [mem_pkg::DATA_W-1:0] mem_rdata,
  input  logic                       mem_ready,
  output logic                       mem_valid,
  output logic                       mem_instr,
  output logic [mem_pkg::ADDR_W-1:0] mem_addr,
  output logic                       instr_valid,
  output logic [mem_pkg::DATA_W-1:0] instr,
  output logic [mem_pkg::ADDR_W-1:0] instr_pc
);

  import mem_pkg::*;
  import lsu_pkg::*;

  req_state_t        state;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] req_addr;
  logic              discard;
  logic              issue;
  logic              deliver;

  // Request fields come from registers so they hold across a redirect.
  assign mem_valid = (state == WAIT_READY);
  assign mem_instr = mem_valid;
  assign mem_addr  = req_addr;

  assign issue   = (state == IDLE) && fetch_en && !redirect;
  assign deliver = (state == WAIT_READY) && mem_ready && !discard && !redirect;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state       <= IDLE;
      pc          <= '0;
      discard     <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= deliver;
      case (state)
        IDLE: begin
          if (redirect) begin
            pc <= redirect_pc;
          end else if (fetch_en) begin
            state <= WAIT_READY;
          end
        end
        WAIT_READY: begin
          if (mem_ready) begin
            state   <= IDLE;
            discard <= 1'b0;
            if (redirect) begin
              pc <= redirect_pc;
            end else if (!discard) begin
              pc <= pc + ADDR_W'(4);
            end
          end else if (redirect) begin
            // Word in flight belongs to the old stream.
            pc      <= redirect_pc;
            discard <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr <= pc;
    end
    if (deliver) begin
      instr    <= mem_rdata;
      instr_pc <= req_addr;
    end
  end

  // A live request is the current pc until a redirect marks it stale.
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && (discard || mem_addr == pc))
    else $error("fetch address changed before ready");

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ls_req,
  input  lsu_pkg::lsu_op_t           ls_op,
  input  logic [mem_pkg::ADDR_W-1:0] ls_addr,
  input  logic [mem_pkg::DATA_W-1:0] ls_wdata,
  input  logic [mem_pkg::DATA_W-1:0] mem_rdata,
  input  logic                       mem_ready,
  output logic                       ls_busy,
  output logic                       ls_done,
  output logic [mem_pkg::DATA_W-1:0] ls_rdata,
  output logic                       mem_valid,
  output logic [mem_pkg::ADDR_W-1:0] mem_addr,
  output logic [mem_pkg::DATA_W-1:0] mem_wdata,
  output logic [mem_pkg::STRB_W-1:0] mem_wstrb
);

  import mem_pkg::*;
  import lsu_pkg::*;

  req_state_t        state;
  lsu_op_t           op_q;
  logic [ADDR_W-1:0] addr_q;
  logic              accept;
  logic              finish;
  logic [DATA_W-1:0] store_data;
  logic [STRB_W-1:0] store_strb;
  logic [DATA_W-1:0] load_data;
  logic [7:0]        ld_byte;
  logic [15:0]       ld_half;

  assign accept = ls_req && (state == IDLE);
  assign finish = (state == WAIT_READY) && mem_ready;

  assign ls_busy   = (state == WAIT_READY);
  assign mem_valid = ls_busy;
  assign mem_addr  = {addr_q[ADDR_W-1:2], 2'b00};

  // ---------------------------------------------------------------------
  // Store lane placement.
  // ---------------------------------------------------------------------
  always_comb begin
    store_data = ls_wdata;
    store_strb = '0;
    case (ls_op)
      OP_SB: begin
        store_data = {4{ls_wdata[7:0]}};
        store_strb = STRB_W'(1) << ls_addr[1:0];
      end
      OP_SH: begin
        store_data = {2{ls_wdata[15:0]}};
        store_strb = ls_addr[1] ? 4'b1100 : 4'b0011;
      end
      OP_SW: store_strb = '1;
      default: store_strb = '0;
    endcase
  end

  // ---------------------------------------------------------------------
  // Load lane select and extension.
  // ---------------------------------------------------------------------
  always_comb begin
    ld_byte = mem_rdata[8*addr_q[1:0] +: 8];
    ld_half = addr_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];
    case (op_q)
      OP_LB:   load_data = {{24{ld_byte[7]}}, ld_byte};
      OP_LBU:  load_data = {24'b0, ld_byte};
      OP_LH:   load_data = {{16{ld_half[15]}}, ld_half};
      OP_LHU:  load_data = {16'b0, ld_half};
      default: load_data = mem_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= IDLE;
      ls_done <= 1'b0;
    end else begin
      ls_done <= finish;
      if (accept) begin
        state <= WAIT_READY;
      end else if (finish) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= ls_op;
      addr_q    <= ls_addr;
      mem_wdata <= store_data;
      mem_wstrb <= store_strb;
    end
    if (finish && !is_store(op_q)) begin
      ls_rdata <= load_data;
    end
  end

  a_no_req_busy : assert property (@(posedge clk) disable iff (!rst)
    ls_req |-> !ls_busy)
    else $error("ls_req while LSU busy");

  a_half_align : assert property (@(posedge clk) disable iff (!rst)
    ls_req && (ls_op inside {OP_LH, OP_LHU, OP_SH}) |-> ls_addr[0] == 1'b0)
    else $error("misaligned halfword access");

  a_word_align : assert property (@(posedge clk) disable iff (!rst)
    ls_req && (ls_op inside {OP_LW, OP_SW}) |-> ls_addr[1:0] == 2'b00)
    else $error("misaligned word access");

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_mem_valid,
  input  logic                       i_mem_instr,
  input  logic [mem_pkg::ADDR_W-1:0] i_mem_addr,
  input  logic                       d_mem_valid,
  input  logic [mem_pkg::ADDR_W-1:0] d_mem_addr,
  input  logic [mem_pkg::DATA_W-1:0] d_mem_wdata,
  input  logic [mem_pkg::STRB_W-1:0] d_mem_wstrb,
  input  logic [mem_pkg::DATA_W-1:0] ram_rdata,
  input  logic                       ram_ready,
  output logic [mem_pkg::DATA_W-1:0] i_mem_rdata,
  output logic                       i_mem_ready,
  output logic [mem_pkg::DATA_W-1:0] d_mem_rdata,
  output logic                       d_mem_ready,
  output logic                       ram_valid,
  output logic                       ram_instr,
  output logic [mem_pkg::ADDR_W-1:0] ram_addr,
  output logic [mem_pkg::DATA_W-1:0] ram_wdata,
  output logic [mem_pkg::STRB_W-1:0] ram_wstrb
);

  import mem_pkg::*;

  owner_t owner;
  owner_t sel;
  logic   locked;
  logic   i_own;
  logic   d_own;

  // Data wins a free bus; a locked bus stays with its owner.
  always_comb begin
    if (locked) begin
      sel = owner;
    end else if (d_mem_valid) begin
      sel = OWNER_DATA;
    end else begin
      sel = OWNER_INSTR;
    end
  end

  always_comb begin
    ram_instr = 1'b0;
    ram_wdata = '0;
    ram_wstrb = '0;
    if (sel == OWNER_DATA) begin
      ram_valid = d_mem_valid;
      ram_addr  = d_mem_addr;
      ram_wdata = d_mem_wdata;
      ram_wstrb = d_mem_wstrb;
    end else begin
      ram_valid = i_mem_valid;
      ram_instr = i_mem_instr;
      ram_addr  = i_mem_addr;
    end
  end

  assign i_own = locked && (owner == OWNER_INSTR);
  assign d_own = locked && (owner == OWNER_DATA);

  assign i_mem_ready = i_own && ram_ready;
  assign d_mem_ready = d_own && ram_ready;
  assign i_mem_rdata = i_own ? ram_rdata : '0;
  assign d_mem_rdata = d_own ? ram_rdata : '0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      owner  <= OWNER_INSTR;
      locked <= 1'b0;
    end else if (ram_ready) begin
      owner  <= OWNER_INSTR;
      locked <= 1'b0;
    end else if (!locked && ram_valid) begin
      owner  <= sel;
      locked <= 1'b1;
    end
  end

  // Each RAM completion reaches exactly one requester.
  a_one_ready : assert property (@(posedge clk) disable iff (!rst)
    ram_ready |-> $onehot({i_mem_ready, d_mem_ready}))
    else $error("ready not delivered to exactly one side");

endmodule

// File: src/wait_state_ram.sv
`timescale 1ns/1ns

module wait_state_ram (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ram_valid,
  input  logic                       ram_instr,
  input  logic [mem_pkg::ADDR_W-1:0] ram_addr,
  input  logic [mem_pkg::DATA_W-1:0] ram_wdata,
  input  logic [mem_pkg::STRB_W-1:0] ram_wstrb,
  output logic [mem_pkg::DATA_W-1:0] ram_rdata,
  output logic                       ram_ready
);

  import mem_pkg::*;

  logic [DATA_W-1:0]     mem [MEM_WORDS];
  logic                  busy;
  logic [WAIT_CNT_W-1:0] cnt;
  logic [WORD_IDX_W-1:0] idx_q;
  logic [DATA_W-1:0]     wdata_q;
  logic [STRB_W-1:0]     wstrb_q;
  logic                  accept;
  logic                  fire;

  // No new request while busy or while the ready pulse is out.
  assign accept = ram_valid && !busy && !ram_ready;
  assign fire   = busy && (cnt == WAIT_CNT_W'(WAIT_CYCLES));

  // ---------------------------------------------------------------------
  // Wait-state sequencing.
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      busy      <= 1'b0;
      cnt       <= '0;
      ram_ready <= 1'b0;
    end else begin
      ram_ready <= fire;
      if (accept) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Storage.
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q   <= ram_addr[WORD_IDX_W+1:2];
      wdata_q <= ram_wdata;
      wstrb_q <= ram_wstrb;
    end
    if (fire) begin
      if (wstrb_q != '0) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (wstrb_q[b]) begin
            mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
          end
        end
      end else begin
        ram_rdata <= mem[idx_q];
      end
    end
  end

  a_instr_no_write : assert property (@(posedge clk) disable iff (!rst)
    ram_valid && ram_instr |-> ram_wstrb == '0)
    else $error("instruction access carries write strobes");

  a_addr_range : assert property (@(posedge clk) disable iff (!rst)
    accept |-> ram_addr[ADDR_W-1:WORD_IDX_W+2] == '0)
    else $error("address beyond memory size");

endmodule

// File: src/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_en,
  input  logic                       redirect,
  input  logic [mem_pkg::ADDR_W-1:0] redirect_pc,
  input  logic                       ls_req,
  input  lsu_pkg::lsu_op_t           ls_op,
  input  logic [mem_pkg::ADDR_W-1:0] ls_addr,
  input  logic [mem_pkg::DATA_W-1:0] ls_wdata,
  output logic                       instr_valid,
  output logic [mem_pkg::DATA_W-1:0] instr,
  output logic [mem_pkg::ADDR_W-1:0] instr_pc,
  output logic                       ls_busy,
  output logic                       ls_done,
  output logic [mem_pkg::DATA_W-1:0] ls_rdata
);

  import mem_pkg::*;

  // Instruction side.
  logic              i_mem_valid;
  logic              i_mem_instr;
  logic [ADDR_W-1:0] i_mem_addr;
  logic [DATA_W-1:0] i_mem_rdata;
  logic              i_mem_ready;

  // Data side.
  logic              d_mem_valid;
  logic [ADDR_W-1:0] d_mem_addr;
  logic [DATA_W-1:0] d_mem_wdata;
  logic [STRB_W-1:0] d_mem_wstrb;
  logic [DATA_W-1:0] d_mem_rdata;
  logic              d_mem_ready;

  // Shared RAM side.
  logic              ram_valid;
  logic              ram_instr;
  logic [ADDR_W-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata;
  logic [STRB_W-1:0] ram_wstrb;
  logic [DATA_W-1:0] ram_rdata;
  logic              ram_ready;

  fetch_unit fetch_i (
    .clk, .rst, .fetch_en, .redirect, .redirect_pc,
    .mem_rdata (i_mem_rdata),
    .mem_ready (i_mem_ready),
    .mem_valid (i_mem_valid),
    .mem_instr (i_mem_instr),
    .mem_addr  (i_mem_addr),
    .instr_valid, .instr, .instr_pc
  );

  load_store_unit lsu_i (
    .clk, .rst, .ls_req, .ls_op, .ls_addr, .ls_wdata,
    .mem_rdata (d_mem_rdata),
    .mem_ready (d_mem_ready),
    .ls_busy, .ls_done, .ls_rdata,
    .mem_valid (d_mem_valid),
    .mem_addr  (d_mem_addr),
    .mem_wdata (d_mem_wdata),
    .mem_wstrb (d_mem_wstrb)
  );

  mem_arbiter arb_i (.*);

  wait_state_ram ram_i (.*);

  // A data request on a free bus takes it over on the next edge.
  a_data_priority : assert property (@(posedge clk) disable iff (!rst)
    d_mem_valid && !arb_i.locked |=> arb_i.locked && arb_i.owner == OWNER_DATA)
    else $error("data request lost arbitration on a free bus");

endmodule

// File: test/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

  import lsu_pkg::*;

  localparam logic [31:0] SEED        = 32'h0a20_7d0e;
  localparam int          OP_LIMIT    = 40;
  localparam int          FETCH_LIMIT = 40;

  logic        clk;
  logic        rst;
  logic        fetch_en;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        ls_req;
  lsu_op_t     ls_op;
  logic [31:0] ls_addr;
  logic [31:0] ls_wdata;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        ls_busy;
  logic        ls_done;
  logic [31:0] ls_rdata;

  // Shadow memory and expected responses.
  logic [31:0] shadow [256];
  logic [31:0] rng;
  logic [31:0] exp_rdata;
  logic        exp_load;
  logic [31:0] exp_instr;
  logic [31:0] exp_pc      = '0;
  int          fetch_count = 0;
  logic        armed       = 1'b0;
  logic        started;

  mem_subsystem dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) armed <= 1'b1;

  // Next expected fetch address follows redirects and completed fetches.
  always @(posedge clk) begin
    if (redirect) begin
      exp_pc <= redirect_pc;
    end else if (instr_valid) begin
      exp_pc      <= exp_pc + 32'd4;
      fetch_count <= fetch_count + 1;
    end
  end

  assign exp_instr = shadow[exp_pc[9:2]];

  // ---------------------------------------------------------------------
  // Reference model.
  // ---------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic void merge_store(input lsu_op_t op, input logic [31:0] addr,
                                      input logic [31:0] data);
    int          first;
    int          count;
    logic [31:0] word;
    first = int'(addr[1:0]);
    count = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    word  = shadow[addr[9:2]];
    for (int k = 0; k < count; k++) begin
      word[8*(first+k) +: 8] = data[8*k +: 8];
    end
    shadow[addr[9:2]] = word;
  endfunction

  function automatic logic [31:0] load_value(input lsu_op_t op, input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = shadow[addr[9:2]];
    b    = 8'(word >> (8 * addr[1:0]));
    h    = 16'(word >> (16 * addr[1]));
    case (op)
      OP_LB:   return 32'($signed(b));
      OP_LBU:  return 32'(b);
      OP_LH:   return 32'($signed(h));
      OP_LHU:  return 32'(h);
      default: return word;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus tasks.
  // ---------------------------------------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic run_op(input lsu_op_t op, input logic [31:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    ls_req   = 1'b1;
    ls_op    = op;
    ls_addr  = addr;
    ls_wdata = data;
    if (op inside {OP_SB, OP_SH, OP_SW}) begin
      merge_store(op, addr, data);
      exp_load = 1'b0;
    end else begin
      exp_rdata = load_value(op, addr);
      exp_load  = 1'b1;
    end
    @(negedge clk);
    ls_req = 1'b0;
    while (!ls_done) begin
      if (waited == OP_LIMIT) begin
        abort_run("timeout: load/store command did not complete");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic random_op(input logic [31:0] base, input logic [31:0] mask);
    lsu_op_t     op;
    logic [31:0] addr;
    logic [31:0] pick;
    pick = draw_random();
    op   = lsu_op_t'(pick[2:0]);
    addr = base | ((pick >> 8) & mask);
    if (op inside {OP_LH, OP_LHU, OP_SH}) begin
      addr[0] = 1'b0;
    end else if (op inside {OP_LW, OP_SW}) begin
      addr[1:0] = 2'b00;
    end
    run_op(op, addr, draw_random());
  endtask

  // Redirect lands on a cycle without instr_valid and can be made to hit a fetch in flight.
  task automatic redirect_to(input logic [31:0] target, input logic mid_fetch);
    int waited;
    waited = 0;
    @(negedge clk);
    while (instr_valid || (mid_fetch && !dut_i.i_mem_valid)) begin
      if (waited == FETCH_LIMIT) begin
        abort_run("timeout: no slot found for a redirect");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
  endtask

  task automatic wait_fetches(input int n);
    int target;
    int waited;
    target = fetch_count + n;
    waited = 0;
    while (fetch_count < target) begin
      if (waited == FETCH_LIMIT * n) begin
        abort_run("timeout: instruction fetches did not arrive");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic drain_fetch();
    int waited;
    waited = 0;
    @(negedge clk);
    while (dut_i.i_mem_valid || instr_valid) begin
      if (waited == FETCH_LIMIT) begin
        abort_run("timeout: fetch in flight did not finish");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Checks.
  // ---------------------------------------------------------------------
  a_quiet : assert property (@(posedge clk)
    armed && !started |-> !instr_valid && !ls_busy && !ls_done)
    else abort_run($sformatf("[FAIL] %0t outputs active before first stimulus", $time));

  a_busy_rise : assert property (@(posedge clk) disable iff (!rst)
    ls_req |=> ls_busy)
    else abort_run($sformatf("[FAIL] %0t ls_busy did not rise after ls_req", $time));

  a_done_busy : assert property (@(posedge clk) disable iff (!rst)
    ls_done |-> !ls_busy && $past(ls_busy))
    else abort_run($sformatf("[FAIL] %0t ls_busy did not fall with ls_done", $time));

  a_load_data : assert property (@(posedge clk) disable iff (!rst)
    ls_done && exp_load |-> ls_rdata == exp_rdata)
    else abort_run($sformatf("[FAIL] %0t ls_rdata %h, expected %h", $time,
                             $sampled(ls_rdata), $sampled(exp_rdata)));

  a_instr_pc : assert property (@(posedge clk) disable iff (!rst)
    instr_valid |-> instr_pc == exp_pc)
    else abort_run($sformatf("[FAIL] %0t instr_pc %h, expected %h", $time,
                             $sampled(instr_pc), $sampled(exp_pc)));

  a_instr_data : assert property (@(posedge clk) disable iff (!rst)
    instr_valid |-> instr == exp_instr)
    else abort_run($sformatf("[FAIL] %0t instr %h at pc %h, expected %h", $time,
                             $sampled(instr), $sampled(exp_pc), $sampled(exp_instr)));

  // ---------------------------------------------------------------------
  // Test sequence.
  // ---------------------------------------------------------------------
  initial begin
    rst         = 1'b0;
    fetch_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    ls_req      = 1'b0;
    ls_op       = OP_LW;
    ls_addr     = '0;
    ls_wdata    = '0;
    exp_rdata   = '0;
    exp_load    = 1'b0;
    started     = 1'b0;
    rng         = SEED;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    repeat (4) @(negedge clk);
    started = 1'b1;

    // Fill all of memory with word stores, reading some back at once.
    for (int w = 0; w < 256; w++) begin
      run_op(OP_SW, 32'(w * 4), draw_random() ^ {16'(w), ~16'(w)});
      if (w % 16 == 0) begin
        run_op(OP_LW, 32'(w * 4), 32'h0);
      end
    end

    // Odd byte lanes get the sign bit set.
    for (int lane = 0; lane < 4; lane++) begin
      run_op(OP_SB, 32'h80 + lane, draw_random() | (lane[0] ? 32'h80 : 32'h0));
      run_op(OP_LB, 32'h80 + lane, 32'h0);
      run_op(OP_LBU, 32'h80 + lane, 32'h0);
      run_op(OP_LW, 32'h80, 32'h0);
    end
    for (int half = 0; half < 2; half++) begin
      run_op(OP_SH, 32'h90 + 2 * half, draw_random() | (half != 0 ? 32'h8000 : 32'h0));
      run_op(OP_LH, 32'h90 + 2 * half, 32'h0);
      run_op(OP_LHU, 32'h90 + 2 * half, 32'h0);
      run_op(OP_LW, 32'h90, 32'h0);
    end

    // Sequential fetch, then a redirect while a word is in flight.
    fetch_en = 1'b1;
    redirect_to(32'h40, 1'b0);
    wait_fetches(6);
    redirect_to(32'h100, 1'b1);
    wait_fetches(4);

    // Fetch stays below 0x100 while data traffic uses the upper half.
    redirect_to(32'h0, 1'b0);
    for (int i = 0; i < 40; i++) begin
      if (exp_pc >= 32'h100) begin
        redirect_to(32'h0, 1'b0);
      end
      random_op(32'h200, 32'h1ff);
    end
    fetch_en = 1'b0;
    drain_fetch();

    for (int i = 0; i < 200; i++) begin
      random_op(32'h0, 32'h3ff);
    end

    repeat (2) @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: compile.f
src/mem_pkg.sv
src/lsu_pkg.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/mem_arbiter.sv
src/wait_state_ram.sv
src/mem_subsystem.sv
test/tb_mem_subsystem.sv
